// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ikari_video
FILELIST  = ikari_video.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/ikari_video_top.sv ====
//////////////////////////////////////////////////
// Ikari video top level
// Timing, register file, side layer and palette
// mixer wired into one display path
//////////////////////////////////////////////////
`timescale 1ns/1ns

module ikari_video_top (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_cpu_wr,
    input  logic [video_regs_pkg::CPU_ADDR_BITS-1:0] i_cpu_addr,
    input  logic [7:0]                              i_cpu_data,
    input  logic                                    i_rom_wr,
    input  logic [video_regs_pkg::ROM_ADDR_BITS-1:0] i_rom_addr,
    input  logic [7:0]                              i_rom_data,
    output logic [3:0]                              o_r,
    output logic [3:0]                              o_g,
    output logic [3:0]                              o_b,
    output logic                                    o_hsync,
    output logic                                    o_vsync,
    output logic                                    o_hblank,
    output logic                                    o_vblank,
    output logic                                    o_ce_pixel,
    output logic [video_timing_pkg::H_BITS-1:0]      o_scr_x,
    output logic [video_timing_pkg::V_BITS-1:0]      o_scr_y
);
    import video_timing_pkg::*;

    logic [H_BITS-1:0] fetch_h;
    logic [V_BITS-1:0] fetch_v;
    logic [2:0]        fetch_phase;
    logic              disp_en;
    logic              vram_we;
    logic [9:0]        vram_addr;
    logic [7:0]        vram_data;
    logic              char_we;
    logic [14:0]       char_addr;
    logic              pal_we;
    logic [7:0]        pal_addr;
    logic [7:0]        wr_data;
    logic              flip;
    logic [1:0]        tile_bank;
    logic [2:0]        color_bank;
    logic [6:0]        backdrop;
    logic [3:0]        side_pix;

    video_timing u_timing (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .o_ce_pixel(o_ce_pixel),
        .o_fetch_h(fetch_h),
        .o_fetch_v(fetch_v),
        .o_fetch_phase(fetch_phase),
        .o_disp_en(disp_en),
        .o_hsync(o_hsync),
        .o_vsync(o_vsync),
        .o_hblank(o_hblank),
        .o_vblank(o_vblank),
        .o_scr_x(o_scr_x),
        .o_scr_y(o_scr_y)
    );

    video_regs u_regs (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_cpu_wr(i_cpu_wr),
        .i_cpu_addr(i_cpu_addr),
        .i_cpu_data(i_cpu_data),
        .i_rom_wr(i_rom_wr),
        .i_rom_addr(i_rom_addr),
        .i_rom_data(i_rom_data),
        .o_vram_we(vram_we),
        .o_vram_addr(vram_addr),
        .o_vram_data(vram_data),
        .o_char_we(char_we),
        .o_char_addr(char_addr),
        .o_pal_we(pal_we),
        .o_pal_addr(pal_addr),
        .o_wr_data(wr_data),
        .o_flip(flip),
        .o_tile_bank(tile_bank),
        .o_color_bank(color_bank),
        .o_backdrop(backdrop)
    );

    side_layer u_side (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_ce_pixel(o_ce_pixel),
        .i_fetch_h(fetch_h),
        .i_fetch_v(fetch_v),
        .i_fetch_phase(fetch_phase),
        .i_flip(flip),
        .i_tile_bank(tile_bank),
        .i_vram_we(vram_we),
        .i_vram_addr(vram_addr),
        .i_char_we(char_we),
        .i_char_addr(char_addr),
        .i_wr_data(vram_data),   // Side memory byte
        .o_pix(side_pix)
    );

    palette_mixer u_mixer (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_ce_pixel(o_ce_pixel),
        .i_disp_en(disp_en),
        .i_pix(side_pix),
        .i_color_bank(color_bank),
        .i_backdrop(backdrop),
        .i_pal_we(pal_we),
        .i_pal_addr(pal_addr),
        .i_wr_data(wr_data),
        .o_r(o_r),
        .o_g(o_g),
        .o_b(o_b)
    );

endmodule

// ==== design/palette_mixer.sv ====
//////////////////////////////////////////////////
// Palette mixer
// Backdrop fallback, palette RAM and the RGB
// output register
//////////////////////////////////////////////////
`timescale 1ns/1ns

module palette_mixer (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_ce_pixel,
    input  logic       i_disp_en,
    input  logic [3:0] i_pix,
    input  logic [2:0] i_color_bank,
    input  logic [6:0] i_backdrop,
    input  logic       i_pal_we,
    input  logic [7:0] i_pal_addr,
    input  logic [7:0] i_wr_data,
    output logic [3:0] o_r,
    output logic [3:0] o_g,
    output logic [3:0] o_b
);
    import video_regs_pkg::*;

    logic [11:0] pal [128]; // {B, G, R}
    logic [6:0]  pal_idx;
    logic [11:0] color;

    // Even byte is G:R, odd byte carries B
    always_ff @(posedge i_clk) begin
        if (i_pal_we) begin
            if (i_pal_addr[0]) begin
                pal[i_pal_addr[7:1]][11:8] <= i_wr_data[3:0];
            end else begin
                pal[i_pal_addr[7:1]][7:0] <= i_wr_data;
            end
        end
    end

    assign pal_idx = (i_pix == TRANSPARENT_PIX) ? i_backdrop : {i_color_bank, i_pix};
    assign color   = pal[pal_idx];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_r <= '0;
            o_g <= '0;
            o_b <= '0;
        end else if (i_ce_pixel) begin
            {o_b, o_g, o_r} <= i_disp_en ? color : 12'h000; // Black in blanking
        end
    end

endmodule

// ==== design/side_layer.sv ====
//////////////////////////////////////////////////
// Side (text) tile layer
// Tile RAM, character ROM, per-tile fetch and
// the pixel shifter with screen flip
//////////////////////////////////////////////////
`timescale 1ns/1ns

module side_layer (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_ce_pixel,
    input  logic [video_timing_pkg::H_BITS-1:0] i_fetch_h,
    input  logic [video_timing_pkg::V_BITS-1:0] i_fetch_v,
    input  logic [2:0]                         i_fetch_phase,
    input  logic                               i_flip,
    input  logic [1:0]                         i_tile_bank,
    input  logic                               i_vram_we,
    input  logic [9:0]                         i_vram_addr,
    input  logic                               i_char_we,
    input  logic [14:0]                        i_char_addr,
    input  logic [7:0]                         i_wr_data,
    output logic [3:0]                         o_pix
);
    import video_regs_pkg::*;

    logic [7:0]  vram [1024];      // 32x32 tile codes
    logic [31:0] char_rom [8192];  // One glyph row per word, pixel 0 in bits 31:28

    logic [7:0]  map_x;
    logic [7:0]  map_y;
    logic [7:0]  code_q;
    logic [2:0]  row_q;
    logic [31:0] glyph_q;
    logic [31:0] shift_q;
    logic        flip_q;
    logic        flip_s;

    // Flip reads the map at (255-x, 255-y)
    assign map_x = i_flip ? ~i_fetch_h[7:0] : i_fetch_h[7:0];
    assign map_y = i_flip ? ~i_fetch_v[7:0] : i_fetch_v[7:0];

    always_ff @(posedge i_clk) begin
        if (i_vram_we) begin
            vram[i_vram_addr] <= i_wr_data;
        end
        if (i_char_we) begin
            char_rom[i_char_addr[14:2]][{~i_char_addr[1:0], 3'b000} +: 8] <= i_wr_data;
        end
    end

    // Phase 0 reads the code, phase 1 the glyph row
    always_ff @(posedge i_clk) begin
        if (i_ce_pixel) begin
            if (i_fetch_phase == 3'd0) begin
                code_q <= vram[{map_y[7:3], map_x[7:3]}];
                row_q  <= map_y[2:0];
            end
            if (i_fetch_phase == 3'd1) begin
                glyph_q <= char_rom[{i_tile_bank, code_q, row_q}];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flip_q  <= 1'b0;
            flip_s  <= 1'b0;
            shift_q <= '1;
        end else if (i_ce_pixel) begin
            if (i_fetch_phase == 3'd0) begin
                flip_q <= i_flip; // Kept with the code it fetched
            end
            if (i_fetch_phase == 3'd7) begin
                shift_q <= glyph_q;
                flip_s  <= flip_q;
            end else if (flip_s) begin
                shift_q <= {TRANSPARENT_PIX, shift_q[31:4]};
            end else begin
                shift_q <= {shift_q[27:0], TRANSPARENT_PIX};
            end
        end
    end

    // Flipped tiles leave the shifter right to left
    assign o_pix = flip_s ? shift_q[3:0] : shift_q[31:28];

endmodule

// ==== design/video_regs.sv ====
//////////////////////////////////////////////////
// Video register file
// CPU and download write decode, BSET, SSET and
// backdrop colour registers
//////////////////////////////////////////////////
`timescale 1ns/1ns

module video_regs (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_cpu_wr,
    input  logic [video_regs_pkg::CPU_ADDR_BITS-1:0] i_cpu_addr,
    input  logic [7:0]                              i_cpu_data,
    input  logic                                    i_rom_wr,
    input  logic [video_regs_pkg::ROM_ADDR_BITS-1:0] i_rom_addr,
    input  logic [7:0]                              i_rom_data,
    output logic                                    o_vram_we,
    output logic [9:0]                              o_vram_addr,
    output logic [7:0]                              o_vram_data,
    output logic                                    o_char_we,
    output logic [14:0]                             o_char_addr,
    output logic                                    o_pal_we,
    output logic [7:0]                              o_pal_addr,
    output logic [7:0]                              o_wr_data,
    output logic                                    o_flip,
    output logic [1:0]                              o_tile_bank,
    output logic [2:0]                              o_color_bank,
    output logic [6:0]                              o_backdrop
);
    import video_regs_pkg::*;

    reg_word_u cpu_word;
    logic      vram_hit;
    logic      char_hit;
    logic      pal_hit;

    assign cpu_word = i_cpu_data;
    assign vram_hit = i_cpu_wr && (i_cpu_addr <= VRAM_TOP);
    assign char_hit = i_rom_wr && (i_rom_addr <= CHAR_TOP);
    assign pal_hit  = i_rom_wr && (i_rom_addr >= PAL_BASE) && (i_rom_addr <= PAL_TOP);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_vram_we    <= 1'b0;
            o_char_we    <= 1'b0;
            o_pal_we     <= 1'b0;
            o_flip       <= 1'b0;
            o_tile_bank  <= '0;
            o_color_bank <= '0;
            o_backdrop   <= '0;
        end else begin
            // Side memories share one byte, download wins a collision
            o_vram_we <= vram_hit && !char_hit;
            o_char_we <= char_hit;
            o_pal_we  <= pal_hit;
            if (i_cpu_wr) begin
                case (i_cpu_addr)
                    BSET_ADDR: o_flip <= cpu_word.bset.flip;
                    SSET_ADDR: begin
                        o_tile_bank  <= cpu_word.sset.tile_bank;
                        o_color_bank <= cpu_word.sset.color_bank;
                    end
                    BKCOL_ADDR: o_backdrop <= i_cpu_data[6:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_vram_addr <= i_cpu_addr[9:0];
        o_vram_data <= char_hit ? i_rom_data : i_cpu_data; // Side VRAM or char ROM
        o_char_addr <= i_rom_addr[14:0];
        o_pal_addr  <= i_rom_addr[7:0];
        o_wr_data   <= i_rom_data;
    end

endmodule

// ==== design/video_regs_pkg.sv ====
//////////////////////////////////////////////////
// Video register maps
// CPU and download address maps, and the layout
// of the BSET and SSET register bytes
//////////////////////////////////////////////////

package video_regs_pkg;

    localparam int CPU_ADDR_BITS = 12;
    localparam int ROM_ADDR_BITS = 16;

    // CPU map
    localparam logic [CPU_ADDR_BITS-1:0] VRAM_TOP   = 12'h3FF; // Side VRAM from 0x000
    localparam logic [CPU_ADDR_BITS-1:0] BSET_ADDR  = 12'hC00;
    localparam logic [CPU_ADDR_BITS-1:0] SSET_ADDR  = 12'hC01;
    localparam logic [CPU_ADDR_BITS-1:0] BKCOL_ADDR = 12'hC02;

    // Download map
    localparam logic [ROM_ADDR_BITS-1:0] CHAR_TOP = 16'h7FFF; // Char ROM from 0x0000
    localparam logic [ROM_ADDR_BITS-1:0] PAL_BASE = 16'h8000;
    localparam logic [ROM_ADDR_BITS-1:0] PAL_TOP  = 16'h80FF;

    localparam logic [3:0] TRANSPARENT_PIX = 4'hF;

    typedef struct packed {
        logic [6:0] rsvd;
        logic       flip;       // Screen flip
    } bset_t;

    typedef struct packed {
        logic       rsvd_hi;
        logic [2:0] color_bank;
        logic [1:0] rsvd_lo;
        logic [1:0] tile_bank;
    } sset_t;

    // One CPU byte, read as BSET or SSET by address
    typedef union packed {
        bset_t bset;
        sset_t sset;
    } reg_word_u;

endpackage

// ==== design/video_timing.sv ====
//////////////////////////////////////////////////
// Video timing generator
// Pixel enable, fetch counters and phase, and
// display-aligned sync, blank and coordinates
//////////////////////////////////////////////////
`timescale 1ns/1ns

module video_timing (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    output logic                               o_ce_pixel,
    output logic [video_timing_pkg::H_BITS-1:0] o_fetch_h,
    output logic [video_timing_pkg::V_BITS-1:0] o_fetch_v,
    output logic [2:0]                         o_fetch_phase,
    output logic                               o_disp_en,
    output logic                               o_hsync,
    output logic                               o_vsync,
    output logic                               o_hblank,
    output logic                               o_vblank,
    output logic [video_timing_pkg::H_BITS-1:0] o_scr_x,
    output logic [video_timing_pkg::V_BITS-1:0] o_scr_y
);
    import video_timing_pkg::*;

    logic [PIX_DIV_BITS-1:0] div_q;
    logic                    ce_q;
    logic [H_BITS-1:0]       fh_q;
    logic [V_BITS-1:0]       fv_q;
    logic [H_BITS-1:0]       disp_x;
    logic [V_BITS-1:0]       disp_y;
    logic                    h_act;
    logic                    v_act;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_q <= '0;
            ce_q  <= 1'b0;
        end else begin
            div_q <= (div_q == PIX_DIV_BITS'(PIX_DIV - 1)) ? '0 : div_q + 1'b1;
            ce_q  <= (div_q == PIX_DIV_BITS'(PIX_DIV - 1));
        end
    end

    // Fetch raster, the master count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fh_q <= '0;
            fv_q <= '0;
        end else if (ce_q) begin
            if (fh_q == H_BITS'(H_TOTAL - 1)) begin
                fh_q <= '0;
                fv_q <= (fv_q == V_BITS'(V_TOTAL - 1)) ? '0 : fv_q + 1'b1;
            end else begin
                fh_q <= fh_q + 1'b1;
            end
        end
    end

    // Beam position trails fetch by FETCH_LEAD pixels
    always_comb begin
        if (fh_q >= H_BITS'(FETCH_LEAD)) begin
            disp_x = fh_q - H_BITS'(FETCH_LEAD);
            disp_y = fv_q;
        end else begin
            disp_x = fh_q + H_BITS'(H_TOTAL - FETCH_LEAD); // Tail of previous line
            disp_y = (fv_q == '0) ? V_BITS'(V_TOTAL - 1) : fv_q - 1'b1;
        end
    end

    assign h_act     = (disp_x < H_BITS'(H_ACTIVE));
    assign v_act     = (disp_y < V_BITS'(V_ACTIVE));
    assign o_disp_en = h_act && v_act;

    // Registered on the same enable as the RGB stage
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_scr_x  <= '0;
            o_scr_y  <= '0;
            o_hblank <= 1'b1;
            o_vblank <= 1'b1;
            o_hsync  <= 1'b0;
            o_vsync  <= 1'b0;
        end else if (ce_q) begin
            o_scr_x  <= disp_x;
            o_scr_y  <= disp_y;
            o_hblank <= !h_act;
            o_vblank <= !v_act;
            o_hsync  <= (disp_x >= H_BITS'(HS_START)) &&
                        (disp_x < H_BITS'(HS_START + HS_WIDTH));
            o_vsync  <= (disp_y >= V_BITS'(VS_START)) &&
                        (disp_y < V_BITS'(VS_START + VS_WIDTH));
        end
    end

    assign o_ce_pixel    = ce_q;
    assign o_fetch_h     = fh_q;
    assign o_fetch_v     = fv_q;
    assign o_fetch_phase = fh_q[2:0]; // Pixel within the tile

endmodule

// ==== design/video_timing_pkg.sv ====
//////////////////////////////////////////////////
// Video timing constants
// Raster geometry, sync placement and counter
// widths for the 6.7 MHz pixel clock
//////////////////////////////////////////////////

package video_timing_pkg;

    // 53.6 MHz / 8 = 6.7 MHz pixel rate
    localparam int PIX_DIV      = 8;
    localparam int PIX_DIV_BITS = 3;

    localparam int H_ACTIVE = 256;
    localparam int H_TOTAL  = 384;
    localparam int V_ACTIVE = 224;
    localparam int V_TOTAL  = 264;

    localparam int HS_START = 296;
    localparam int HS_WIDTH = 32;   // Pixels
    localparam int VS_START = 240;
    localparam int VS_WIDTH = 4;    // Lines

    // Fetch runs one tile ahead of the beam
    localparam int FETCH_LEAD = 8;

    localparam int H_BITS = 9;
    localparam int V_BITS = 9;

endpackage

// ==== dv/ikari_video_sva.sv ====
//////////////////////////////////////////////////
// Timing assertions for the video top level
// Pixel enable cadence, sync widths, blank flags
// and black output during blanking
//////////////////////////////////////////////////
`timescale 1ns/1ns

module ikari_video_sva (
    input logic                                i_clk,
    input logic                                i_rst_n,
    input logic                                o_ce_pixel,
    input logic                                o_hsync,
    input logic                                o_vsync,
    input logic                                o_hblank,
    input logic                                o_vblank,
    input logic [3:0]                          o_r,
    input logic [3:0]                          o_g,
    input logic [3:0]                          o_b,
    input logic [video_timing_pkg::H_BITS-1:0] o_scr_x,
    input logic [video_timing_pkg::V_BITS-1:0] o_scr_y
);
    import video_timing_pkg::*;

    int hs_cnt; // Pixel enables seen with hsync high
    int vs_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hs_cnt <= 0;
            vs_cnt <= 0;
        end else if (o_ce_pixel) begin
            hs_cnt <= o_hsync ? hs_cnt + 1 : 0;
            vs_cnt <= o_vsync ? vs_cnt + 1 : 0;
        end
    end

    ce_cadence: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ce_pixel |=> !o_ce_pixel [*PIX_DIV-1] ##1 o_ce_pixel)
        else $error("pixel enable cadence broken");

    hsync_width: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_hsync) |-> hs_cnt == HS_WIDTH)
        else $error("hsync width wrong");

    vsync_width: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_vsync) |-> vs_cnt == VS_WIDTH * H_TOTAL)
        else $error("vsync width wrong");

    // Blank flags mark the pixels outside the active area
    blank_coords: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ce_pixel |=> (o_hblank == (o_scr_x >= H_ACTIVE)) &&
                       (o_vblank == (o_scr_y >= V_ACTIVE)))
        else $error("blank flags disagree with screen coordinates");

    blank_black: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_hblank || o_vblank) |-> {o_r, o_g, o_b} == 12'h000)
        else $error("RGB not black in blanking");

endmodule

bind ikari_video_top ikari_video_sva u_sva (.*);

// ==== dv/tb_ikari_video.sv ====
//////////////////////////////////////////////////
// Ikari video testbench
// Loads ROM, palette and VRAM from a local model
// and checks whole frames against the pixel rule
//////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_ikari_video;
    import video_timing_pkg::*;
    import video_regs_pkg::*;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_cpu_wr;
    logic [11:0] i_cpu_addr;
    logic [7:0]  i_cpu_data;
    logic        i_rom_wr;
    logic [15:0] i_rom_addr;
    logic [7:0]  i_rom_data;
    logic [3:0]  o_r;
    logic [3:0]  o_g;
    logic [3:0]  o_b;
    logic        o_hsync;
    logic        o_vsync;
    logic        o_hblank;
    logic        o_vblank;
    logic        o_ce_pixel;
    logic [8:0]  o_scr_x;
    logic [8:0]  o_scr_y;

    // Reference model of the video memories and registers
    logic [7:0]  vram_m [1024];
    logic [31:0] glyph_m [256][8]; // Tile bank 1 rows, pixel 0 in bits 31:28
    logic [11:0] pal_m [128];      // {B, G, R}
    logic [6:0]  backdrop_m;
    logic [2:0]  cbank_m;
    logic        flip_m;

    ikari_video_top DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s at %0t", msg, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int exp_v, input int got_v);
        assert (exp_v == got_v) else begin
            $display("Fail t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic cpu_write(input logic [11:0] addr, input logic [7:0] data);
        i_cpu_wr   = 1'b1;
        i_cpu_addr = addr;
        i_cpu_data = data;
        @(posedge i_clk);
        #1 i_cpu_wr = 1'b0;
    endtask

    task automatic rom_write(input logic [15:0] addr, input logic [7:0] data);
        i_rom_wr   = 1'b1;
        i_rom_addr = addr;
        i_rom_data = data;
        @(posedge i_clk);
        #1 i_rom_wr = 1'b0;
    endtask

    task automatic set_palette(input int e, input logic [11:0] bgr);
        pal_m[e] = bgr;
        rom_write(16'(32'h8000 + 2 * e), bgr[7:0]);     // G:R
        rom_write(16'(32'h8000 + 2 * e + 1), {4'h0, bgr[11:8]});
    endtask

    // Stops on the negedge after a pixel enable, where outputs are settled
    task automatic next_pixel();
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
            if (n > 4 * PIX_DIV) stop_on_error("Pixel enable never arrived");
        end while (!o_ce_pixel);
        @(negedge i_clk);
    endtask

    function automatic logic [11:0] expected_color(input int x, input int y);
        int mx;
        int my;
        logic [7:0] code;
        logic [3:0] p;
        mx = flip_m ? 255 - x : x;
        my = flip_m ? 255 - y : y;
        code = vram_m[(my / 8) * 32 + mx / 8];
        p = glyph_m[code][my % 8][31 - 4 * (mx % 8) -: 4];
        if (p == 4'hF) return pal_m[backdrop_m];
        return pal_m[cbank_m * 16 + int'(p)];
    endfunction

    // Checks one frame from (0,0) up to the first blanked line
    task automatic check_frame();
        int n;
        logic [11:0] exp_c;
        n = 0;
        do begin
            next_pixel();
            n++;
            if (n > H_TOTAL * V_TOTAL + 1) stop_on_error("Frame start not seen");
        end while (!(o_scr_x == 0 && o_scr_y == 0));
        n = 0;
        while (!(o_scr_x == 0 && o_scr_y == V_ACTIVE)) begin
            if (o_scr_x < H_ACTIVE) exp_c = expected_color(o_scr_x, o_scr_y);
            else exp_c = 12'h000;
            check_value("o_r", exp_c[3:0], o_r);
            check_value("o_g", exp_c[7:4], o_g);
            check_value("o_b", exp_c[11:8], o_b);
            next_pixel();
            n++;
            if (n > H_TOTAL * V_TOTAL) stop_on_error("Frame did not reach blanking");
        end
        // Back to the drive point just after a rising edge
        @(posedge i_clk);
        #1;
    endtask

    initial begin
        int t;
        void'($urandom(50));
        i_rst_n = 1'b0;
        i_cpu_wr = 1'b0;
        i_cpu_addr = '0;
        i_cpu_data = '0;
        i_rom_wr = 1'b0;
        i_rom_addr = '0;
        i_rom_data = '0;
        flip_m = 1'b0;
        cbank_m = 3'd5;
        backdrop_m = 7'h23;
        repeat (8) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        check_value("o_r", 0, o_r);
        check_value("o_g", 0, o_g);
        check_value("o_b", 0, o_b);
        check_value("o_hsync", 0, o_hsync);
        check_value("o_vsync", 0, o_vsync);

        // Codes F0..FF are fully transparent glyphs
        for (int c = 0; c < 256; c++) begin
            for (int r = 0; r < 8; r++) begin
                glyph_m[c][r] = (c >= 8'hF0) ? 32'hFFFF_FFFF : $urandom;
                t = ((256 + c) * 8 + r) * 4;
                for (int k = 0; k < 4; k++) begin
                    rom_write(16'(t + k), glyph_m[c][r][31 - 8 * k -: 8]);
                end
            end
        end
        for (int e = 0; e < 128; e++) set_palette(e, 12'($urandom));
        for (int a = 0; a < 1024; a++) begin
            vram_m[a] = 8'($urandom);
            cpu_write(12'(a), vram_m[a]);
        end
        cpu_write(SSET_ADDR, 8'h51); // Colour bank 5, tile bank 1
        cpu_write(BKCOL_ADDR, {1'b0, backdrop_m});
        check_frame();

        backdrop_m = 7'h47;
        cpu_write(BKCOL_ADDR, {1'b0, backdrop_m});
        check_frame();

        flip_m = 1'b1;
        cpu_write(BSET_ADDR, 8'h01);
        check_frame();

        set_palette(16'h55, ~pal_m[8'h55]);
        check_frame();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== ikari_video.f ====
design/video_timing_pkg.sv
design/video_regs_pkg.sv
design/video_timing.sv
design/video_regs.sv
design/side_layer.sv
design/palette_mixer.sv
design/ikari_video_top.sv
dv/ikari_video_sva.sv
dv/tb_ikari_video.sv
